// File: frame_dl_pkg.sv
package frame_dl_pkg;

    localparam int PIXEL_BITS = 16;
    localparam int QUEUE_BITS = PIXEL_BITS + 1;       // pixel plus start-of-frame flag
    localparam int ADDR_BITS  = 21;                   // pixel address

    localparam int WORD_BITS    = 2 * PIXEL_BITS;     // one memory word
    localparam int WORD_BYTES   = WORD_BITS / 8;
    localparam int PIX_PER_WORD = WORD_BITS / PIXEL_BITS;

    // one memory word, seen either as received or as two pixels
    typedef union packed {
        logic [WORD_BITS-1:0] raw;
        struct packed {
            logic [PIXEL_BITS-1:0] pix_hi;            // odd address
            logic [PIXEL_BITS-1:0] pix_lo;            // even address
        } pix;
    } cache_word_t;

endpackage

// File: frame_addr_gen.sv
module frame_addr_gen
    import frame_dl_pkg::*;
#(
    parameter int MEMORY_BURST     = 32,
    parameter int FRAME_WIDTH      = 480,
    parameter int FRAME_HEIGHT     = 272,
    parameter int ORIG_FRAME_WIDTH = 640
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 load,
    input  logic [ADDR_BITS-1:0] base_addr,
    input  logic                 advance,
    output logic [ADDR_BITS-1:0] burst_addr,
    output logic                 last_burst
);

    localparam int BURST_PIX = MEMORY_BURST / WORD_BYTES * PIX_PER_WORD;
    localparam int ROW_BITS  = $clog2(FRAME_HEIGHT + 1);

    localparam logic [ADDR_BITS-1:0] COL_STEP = ADDR_BITS'(BURST_PIX);
    localparam logic [ADDR_BITS-1:0] LAST_COL = ADDR_BITS'(FRAME_WIDTH - BURST_PIX);
    localparam logic [ADDR_BITS-1:0] STRIDE   = ADDR_BITS'(ORIG_FRAME_WIDTH);
    localparam logic [ROW_BITS-1:0]  LAST_ROW = ROW_BITS'(FRAME_HEIGHT - 1);

    logic [ADDR_BITS-1:0] row_start;
    logic [ADDR_BITS-1:0] col_off;
    logic [ROW_BITS-1:0]  row_cnt;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            row_start <= '0;
            col_off   <= '0;
            row_cnt   <= '0;
        end else if (load) begin
            row_start <= base_addr;
            col_off   <= '0;
            row_cnt   <= '0;
        end else if (advance) begin
            if (col_off == LAST_COL) begin              // end of window row
                col_off   <= '0;
                row_start <= row_start + STRIDE;
                row_cnt   <= row_cnt + 1'b1;
            end else begin
                col_off <= col_off + COL_STEP;
            end
        end
    end

    assign burst_addr = row_start + col_off;
    assign last_burst = (row_cnt == LAST_ROW) && (col_off == LAST_COL);

endmodule

// File: burst_reader.sv
module burst_reader
    import frame_dl_pkg::*;
#(
    parameter int MEMORY_BURST = 32
) (
    input  logic                                         clk,
    input  logic                                         reset_n,
    input  logic                                         burst_go,
    input  logic [ADDR_BITS-1:0]                         burst_addr,
    input  logic                                         fill_half,
    output logic                                         burst_busy,
    output logic                                         fill_done,
    output logic                                         read_rq,
    output logic [ADDR_BITS-1:0]                         read_addr,
    output logic                                         mem_rd_en,
    input  logic                                         read_ack,
    input  logic [WORD_BITS-1:0]                         read_data,
    output logic                                         cache_we,
    output logic [$clog2(MEMORY_BURST / WORD_BYTES):0]   cache_waddr,
    output cache_word_t                                  cache_wdata
);

    localparam int BURST_WORDS = MEMORY_BURST / WORD_BYTES;
    localparam int WCNT_BITS   = $clog2(BURST_WORDS);

    localparam logic [WCNT_BITS-1:0] LAST_WORD = WCNT_BITS'(BURST_WORDS - 1);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_REQ   = 2'd1;
    localparam logic [1:0] S_READ  = 2'd2;
    localparam logic [1:0] S_FLUSH = 2'd3;              // last word still in flight

    logic [1:0]           state;
    logic [WCNT_BITS-1:0] word_cnt;
    logic [WCNT_BITS-1:0] wr_cnt;
    logic                 half_q;
    logic                 wr_pend;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= S_IDLE;
            word_cnt  <= '0;
            wr_pend   <= 1'b0;
            fill_done <= 1'b0;
        end else begin
            wr_pend   <= mem_rd_en;                     // data returns one cycle later
            fill_done <= (state == S_FLUSH);
            case (state)
                S_IDLE: begin
                    if (burst_go)
                        state <= S_REQ;
                end
                S_REQ: begin
                    if (read_ack) begin
                        state    <= S_READ;
                        word_cnt <= '0;
                    end
                end
                S_READ: begin
                    word_cnt <= word_cnt + 1'b1;
                    if (word_cnt == LAST_WORD)
                        state <= S_FLUSH;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && burst_go) begin
            read_addr <= burst_addr;                    // held through the handshake
            half_q    <= fill_half;
        end
        wr_cnt <= word_cnt;
    end

    assign burst_busy = (state != S_IDLE);
    assign read_rq    = (state == S_REQ);
    assign mem_rd_en  = (state == S_READ);

    assign cache_we        = wr_pend;
    assign cache_waddr     = {half_q, wr_cnt};
    assign cache_wdata.raw = read_data;

endmodule

// File: download_cache.sv
module download_cache
    import frame_dl_pkg::*;
#(
    parameter int MEMORY_BURST = 32
) (
    input  logic                                         clk,
    input  logic                                         cache_we,
    input  logic [$clog2(MEMORY_BURST / WORD_BYTES):0]   cache_waddr,
    input  cache_word_t                                  cache_wdata,
    input  logic                                         cache_re,
    input  logic [$clog2(MEMORY_BURST / WORD_BYTES):0]   cache_raddr,
    output cache_word_t                                  cache_rdata
);

    // two halves of one burst each, selected by the address msb
    localparam int DEPTH = 2 * (MEMORY_BURST / WORD_BYTES);

    logic [WORD_BITS-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (cache_we)
            mem[cache_waddr] <= cache_wdata.raw;
    end

    always_ff @(posedge clk) begin
        if (cache_re)
            cache_rdata.raw <= mem[cache_raddr];        // holds between reads
    end

endmodule

// File: frame_downloader.sv
module frame_downloader
    import frame_dl_pkg::*;
#(
    parameter int MEMORY_BURST = 32
) (
    input  logic                                         clk,
    input  logic                                         reset_n,
    input  logic                                         start,
    input  logic [ADDR_BITS-1:0]                         base_addr,
    output logic                                         download_done,
    output logic                                         addr_load,
    output logic                                         addr_advance,
    input  logic [ADDR_BITS-1:0]                         burst_addr_in,
    input  logic                                         last_burst,
    output logic                                         burst_go,
    output logic                                         fill_half,
    input  logic                                         burst_busy,
    input  logic                                         fill_done,
    output logic                                         cache_re,
    output logic [$clog2(MEMORY_BURST / WORD_BYTES):0]   cache_raddr,
    input  cache_word_t                                  cache_rdata,
    input  logic                                         queue_full,
    output logic                                         wr_en,
    output logic [QUEUE_BITS-1:0]                        queue_data
);

    localparam int BURST_PIX = MEMORY_BURST / WORD_BYTES * PIX_PER_WORD;
    localparam int PCNT_BITS = $clog2(BURST_PIX);

    localparam logic [PCNT_BITS-1:0] LAST_PIX = PCNT_BITS'(BURST_PIX - 1);

    logic                 running;
    logic                 fill_busy;
    logic                 issued_all;
    logic                 fill_ptr;
    logic                 drain_ptr;
    logic                 drain_act;
    logic [1:0]           half_valid;
    logic [1:0]           half_sof;                 // half holds the frame's first burst
    logic [1:0]           half_last;                // half holds the frame's last burst
    logic [ADDR_BITS-1:0] base_q;
    logic [PCNT_BITS-1:0] pix_cnt;
    logic                 drain_start;
    logic                 drain_end;
    logic                 sel_hi;
    logic                 sof_q;
    logic                 last_q;

    assign addr_load    = start && !running;
    assign burst_go     = running && !fill_busy && !burst_busy && !issued_all &&
                          !half_valid[fill_ptr];
    assign addr_advance = burst_go;
    assign fill_half    = fill_ptr;

    // a half is drained in one go, so wait for room for a whole burst
    assign drain_start = running && !drain_act && half_valid[drain_ptr] &&
                         !queue_full && !wr_en;
    assign drain_end   = drain_act && (pix_cnt == LAST_PIX);

    assign cache_re    = drain_act && !pix_cnt[0];  // one word per two pixels
    assign cache_raddr = {drain_ptr, pix_cnt[PCNT_BITS-1:1]};
    assign queue_data  = {sof_q, sel_hi ? cache_rdata.pix.pix_hi : cache_rdata.pix.pix_lo};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            running       <= 1'b0;
            fill_busy     <= 1'b0;
            issued_all    <= 1'b0;
            fill_ptr      <= 1'b0;
            drain_ptr     <= 1'b0;
            drain_act     <= 1'b0;
            half_valid    <= 2'b00;
            pix_cnt       <= '0;
            wr_en         <= 1'b0;
            download_done <= 1'b0;
        end else begin
            wr_en         <= drain_act;
            download_done <= wr_en && last_q;

            if (addr_load)
                running <= 1'b1;
            else if (wr_en && last_q)
                running <= 1'b0;

            if (addr_load)
                issued_all <= 1'b0;
            else if (burst_go)
                issued_all <= last_burst;

            if (burst_go) begin
                fill_busy <= 1'b1;
            end else if (fill_done) begin
                fill_busy <= 1'b0;
                fill_ptr  <= ~fill_ptr;
            end

            if (fill_done)
                half_valid[fill_ptr] <= 1'b1;
            if (drain_end)
                half_valid[drain_ptr] <= 1'b0;

            if (drain_start) begin
                drain_act <= 1'b1;
                pix_cnt   <= '0;
            end else if (drain_act) begin
                pix_cnt <= pix_cnt + 1'b1;
                if (drain_end) begin
                    drain_act <= 1'b0;
                    drain_ptr <= ~drain_ptr;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (addr_load)
            base_q <= base_addr;
        if (burst_go) begin
            half_sof[fill_ptr]  <= (burst_addr_in == base_q);
            half_last[fill_ptr] <= last_burst;
        end
        sel_hi <= pix_cnt[0];                       // aligns with cache read latency
        sof_q  <= half_sof[drain_ptr] && (pix_cnt == '0);
        last_q <= half_last[drain_ptr] && drain_end;
    end

endmodule

// File: pixel_queue.sv
module pixel_queue
    import frame_dl_pkg::*;
#(
    parameter int QUEUE_DEPTH  = 64,
    parameter int MEMORY_BURST = 32
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  wr_en,
    input  logic [QUEUE_BITS-1:0] queue_data,
    output logic                  queue_full,
    input  logic                  queue_rd,
    output logic                  queue_valid,
    output logic [QUEUE_BITS-1:0] queue_data_out
);

    localparam int BURST_PIX = MEMORY_BURST / WORD_BYTES * PIX_PER_WORD;
    localparam int PTR_BITS  = $clog2(QUEUE_DEPTH);
    localparam int CNT_BITS  = PTR_BITS + 1;

    localparam logic [PTR_BITS-1:0] LAST_SLOT = PTR_BITS'(QUEUE_DEPTH - 1);
    localparam logic [CNT_BITS-1:0] DEPTH_CNT = CNT_BITS'(QUEUE_DEPTH);
    localparam logic [CNT_BITS-1:0] FULL_AT   = CNT_BITS'(QUEUE_DEPTH - BURST_PIX);

    logic [QUEUE_BITS-1:0] mem [QUEUE_DEPTH];
    logic [PTR_BITS-1:0]   wr_ptr;
    logic [PTR_BITS-1:0]   rd_ptr;
    logic [CNT_BITS-1:0]   count;
    logic                  push;
    logic                  pop;

    assign push = wr_en && (count != DEPTH_CNT);
    assign pop  = queue_rd && queue_valid;

    assign queue_valid    = (count != '0);
    assign queue_full     = (count > FULL_AT);      // less than one burst free
    assign queue_data_out = mem[rd_ptr];            // show-ahead

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= queue_data;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: frame_fetch_top.sv
module frame_fetch_top
    import frame_dl_pkg::*;
#(
    parameter int MEMORY_BURST     = 32,
    parameter int FRAME_WIDTH      = 480,
    parameter int FRAME_HEIGHT     = 272,
    parameter int ORIG_FRAME_WIDTH = 640,
    parameter int QUEUE_DEPTH      = 64
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  start,
    input  logic [ADDR_BITS-1:0]  base_addr,
    output logic                  download_done,
    output logic                  read_rq,
    output logic [ADDR_BITS-1:0]  read_addr,
    input  logic                  read_ack,
    output logic                  mem_rd_en,
    input  logic [WORD_BITS-1:0]  read_data,
    input  logic                  queue_rd,
    output logic                  queue_valid,
    output logic [QUEUE_BITS-1:0] queue_data_out
);

    localparam int CACHE_AW = $clog2(MEMORY_BURST / WORD_BYTES) + 1;

    logic                  addr_load;
    logic                  addr_advance;
    logic [ADDR_BITS-1:0]  burst_addr;
    logic                  last_burst;
    logic                  burst_go;
    logic                  fill_half;
    logic                  burst_busy;
    logic                  fill_done;
    logic                  cache_we;
    logic [CACHE_AW-1:0]   cache_waddr;
    cache_word_t           cache_wdata;
    logic                  cache_re;
    logic [CACHE_AW-1:0]   cache_raddr;
    cache_word_t           cache_rdata;
    logic                  queue_full;
    logic                  wr_en;
    logic [QUEUE_BITS-1:0] queue_data;

    frame_addr_gen #(
        .MEMORY_BURST     (MEMORY_BURST),
        .FRAME_WIDTH      (FRAME_WIDTH),
        .FRAME_HEIGHT     (FRAME_HEIGHT),
        .ORIG_FRAME_WIDTH (ORIG_FRAME_WIDTH)
    ) u_addr_gen (
        .clk        (clk),
        .reset_n    (reset_n),
        .load       (addr_load),
        .base_addr  (base_addr),
        .advance    (addr_advance),
        .burst_addr (burst_addr),
        .last_burst (last_burst)
    );

    burst_reader #(
        .MEMORY_BURST (MEMORY_BURST)
    ) u_reader (
        .clk         (clk),
        .reset_n     (reset_n),
        .burst_go    (burst_go),
        .burst_addr  (burst_addr),
        .fill_half   (fill_half),
        .burst_busy  (burst_busy),
        .fill_done   (fill_done),
        .read_rq     (read_rq),
        .read_addr   (read_addr),
        .mem_rd_en   (mem_rd_en),
        .read_ack    (read_ack),
        .read_data   (read_data),
        .cache_we    (cache_we),
        .cache_waddr (cache_waddr),
        .cache_wdata (cache_wdata)
    );

    download_cache #(
        .MEMORY_BURST (MEMORY_BURST)
    ) u_cache (
        .clk         (clk),
        .cache_we    (cache_we),
        .cache_waddr (cache_waddr),
        .cache_wdata (cache_wdata),
        .cache_re    (cache_re),
        .cache_raddr (cache_raddr),
        .cache_rdata (cache_rdata)
    );

    frame_downloader #(
        .MEMORY_BURST (MEMORY_BURST)
    ) u_downloader (
        .clk           (clk),
        .reset_n       (reset_n),
        .start         (start),
        .base_addr     (base_addr),
        .download_done (download_done),
        .addr_load     (addr_load),
        .addr_advance  (addr_advance),
        .burst_addr_in (burst_addr),
        .last_burst    (last_burst),
        .burst_go      (burst_go),
        .fill_half     (fill_half),
        .burst_busy    (burst_busy),
        .fill_done     (fill_done),
        .cache_re      (cache_re),
        .cache_raddr   (cache_raddr),
        .cache_rdata   (cache_rdata),
        .queue_full    (queue_full),
        .wr_en         (wr_en),
        .queue_data    (queue_data)
    );

    pixel_queue #(
        .QUEUE_DEPTH  (QUEUE_DEPTH),
        .MEMORY_BURST (MEMORY_BURST)
    ) u_queue (
        .clk            (clk),
        .reset_n        (reset_n),
        .wr_en          (wr_en),
        .queue_data     (queue_data),
        .queue_full     (queue_full),
        .queue_rd       (queue_rd),
        .queue_valid    (queue_valid),
        .queue_data_out (queue_data_out)
    );

endmodule

// File: tb_mem_model.sv
module tb_mem_model
    import frame_dl_pkg::*;
#(
    parameter int ACK_DELAY_MAX = 7
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 read_rq,
    input  logic [ADDR_BITS-1:0] read_addr,
    output logic                 read_ack,
    input  logic                 mem_rd_en,
    output logic [WORD_BITS-1:0] read_data
);

    int                   wait_left;
    logic                 waiting;
    logic                 data_pend;
    logic [ADDR_BITS-1:0] next_addr;
    logic [ADDR_BITS-1:0] pend_addr;

    function automatic logic [PIXEL_BITS-1:0] pixel_value(input logic [ADDR_BITS-1:0] addr);
        return addr[PIXEL_BITS-1:0] ^ 16'h5a5a;
    endfunction

    initial begin
        read_ack  = 1'b0;
        read_data = '0;
        waiting   = 1'b0;
        data_pend = 1'b0;
        wait_left = 0;
        next_addr = '0;
        pend_addr = '0;
        forever begin
            @(negedge clk or negedge reset_n);
            if (!reset_n) begin
                read_ack  = 1'b0;
                waiting   = 1'b0;
                data_pend = 1'b0;
            end else begin
                // word for the previous rd_en cycle, held through the next one
                if (data_pend)
                    read_data = {pixel_value(pend_addr + 1'b1), pixel_value(pend_addr)};
                data_pend = mem_rd_en;
                if (mem_rd_en) begin
                    pend_addr = next_addr;
                    next_addr = next_addr + 2'd2;   // two pixels per word
                end
                if (read_ack) begin
                    read_ack = 1'b0;                // one-cycle pulse
                end else if (read_rq) begin
                    if (!waiting) begin
                        wait_left = $urandom_range(ACK_DELAY_MAX, 0);
                        waiting   = 1'b1;
                    end
                    if (wait_left == 0) begin
                        read_ack  = 1'b1;
                        waiting   = 1'b0;
                        next_addr = read_addr;
                    end else begin
                        wait_left--;
                    end
                end
            end
        end
    end

endmodule

// File: tb_frame_fetch.sv
module tb_frame_fetch
    import frame_dl_pkg::*;
();

    localparam int FRAME_WIDTH      = 32;
    localparam int FRAME_HEIGHT     = 4;
    localparam int ORIG_FRAME_WIDTH = 48;
    localparam int MEMORY_BURST     = 32;
    localparam int QUEUE_DEPTH      = 32;
    localparam int CLK_PERIOD       = 4;
    localparam int SEED             = 32'h816f;
    localparam int BURST_PIX        = MEMORY_BURST / 2;     // 16-bit pixels
    localparam int BURST_WORDS      = BURST_PIX / 2;        // two pixels per word
    localparam int FRAME_PIX        = FRAME_WIDTH * FRAME_HEIGHT;
    localparam int FRAME_BURSTS     = FRAME_PIX / BURST_PIX;
    localparam int N_FRAMES         = 3;
    localparam int TOTAL_PIX        = N_FRAMES * FRAME_PIX;
    localparam int TOTAL_BURSTS     = N_FRAMES * FRAME_BURSTS;
    localparam int WATCHDOG_CYCLES  = N_FRAMES * FRAME_PIX * 20;

    logic                  clk;
    logic                  reset_n;
    logic                  start;
    logic [ADDR_BITS-1:0]  base_addr;
    logic                  download_done;
    logic                  read_rq;
    logic [ADDR_BITS-1:0]  read_addr;
    logic                  read_ack;
    logic                  mem_rd_en;
    logic [WORD_BITS-1:0]  read_data;
    logic                  queue_rd;
    logic                  queue_valid;
    logic [QUEUE_BITS-1:0] queue_data_out;

    logic [QUEUE_BITS-1:0] exp_pix [TOTAL_PIX];
    logic [ADDR_BITS-1:0]  exp_burst [TOTAL_BURSTS];
    logic [ADDR_BITS-1:0]  frame_base [N_FRAMES];
    logic [QUEUE_BITS-1:0] exp_entry;
    logic [ADDR_BITS-1:0]  exp_baddr;
    int                    cons_idx;
    int                    burst_idx;
    int                    done_cnt;
    int                    rd_run;                       // rd_en cycles since the last ack
    int                    frame_idx = 0;
    int                    frame_end = 0;
    int                    mismatch_cnt = 0;
    int                    other_cnt = 0;
    string                 test_name = "reset";

    frame_fetch_top #(
        .MEMORY_BURST     (MEMORY_BURST),
        .FRAME_WIDTH      (FRAME_WIDTH),
        .FRAME_HEIGHT     (FRAME_HEIGHT),
        .ORIG_FRAME_WIDTH (ORIG_FRAME_WIDTH),
        .QUEUE_DEPTH      (QUEUE_DEPTH)
    ) DUT (
        .clk            (clk),
        .reset_n        (reset_n),
        .start          (start),
        .base_addr      (base_addr),
        .download_done  (download_done),
        .read_rq        (read_rq),
        .read_addr      (read_addr),
        .read_ack       (read_ack),
        .mem_rd_en      (mem_rd_en),
        .read_data      (read_data),
        .queue_rd       (queue_rd),
        .queue_valid    (queue_valid),
        .queue_data_out (queue_data_out)
    );

    tb_mem_model u_mem (
        .clk       (clk),
        .reset_n   (reset_n),
        .read_rq   (read_rq),
        .read_addr (read_addr),
        .read_ack  (read_ack),
        .mem_rd_en (mem_rd_en),
        .read_data (read_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    assign exp_entry = (cons_idx < TOTAL_PIX) ? exp_pix[cons_idx] : '0;
    assign exp_baddr = (burst_idx < TOTAL_BURSTS) ? exp_burst[burst_idx] : '0;

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cons_idx  <= 0;
            burst_idx <= 0;
            done_cnt  <= 0;
            rd_run    <= 0;
        end else begin
            if (queue_valid && queue_rd)
                cons_idx <= cons_idx + 1;
            if (read_rq && read_ack)
                burst_idx <= burst_idx + 1;
            if (download_done)
                done_cnt <= done_cnt + 1;
            if (read_rq && read_ack)
                rd_run <= 0;
            else if (mem_rd_en)
                rd_run <= rd_run + 1;
        end
    end

    a_pixel: assert property (@(posedge clk) disable iff (!reset_n)
        (queue_valid && queue_rd && cons_idx < frame_end) |-> queue_data_out == exp_entry)
        else begin
            mismatch_cnt++;
            $display("Mismatch %s: expected %h, actual %h", test_name,
                     $sampled(exp_entry), $sampled(queue_data_out));
        end

    a_no_extra: assert property (@(posedge clk) disable iff (!reset_n)
        (queue_valid && queue_rd) |-> cons_idx < frame_end)
        else begin
            other_cnt++;
            $display("Error in %s: an entry was read past the end of the frame", test_name);
        end

    a_done_once: assert property (@(posedge clk) disable iff (!reset_n)
        download_done |-> done_cnt == frame_idx)
        else begin
            other_cnt++;
            $display("Error in %s: download_done pulsed more than once", test_name);
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        download_done |=> !download_done)
        else begin
            other_cnt++;
            $display("Error in %s: download_done was longer than one cycle", test_name);
        end

    a_addr_hold: assert property (@(posedge clk) disable iff (!reset_n)
        (read_rq && !read_ack) |=> (read_rq && $stable(read_addr)))
        else begin
            other_cnt++;
            $display("Error in %s: read request changed before acknowledge", test_name);
        end

    a_burst_addr: assert property (@(posedge clk) disable iff (!reset_n)
        (read_rq && read_ack) |-> read_addr == exp_baddr)
        else begin
            mismatch_cnt++;
            $display("Mismatch %s burst address: expected %h, actual %h", test_name,
                     $sampled(exp_baddr), $sampled(read_addr));
        end

    a_rd_burst: assert property (@(posedge clk) disable iff (!reset_n)
        $fell(mem_rd_en) |-> rd_run == BURST_WORDS)
        else begin
            mismatch_cnt++;
            $display("Mismatch %s read burst length: expected %0d, actual %0d", test_name,
                     BURST_WORDS, $sampled(rd_run));
        end

    // row-major walk of every frame's window
    task automatic build_reference();
        logic [ADDR_BITS-1:0] addr;
        int                   n;
        int                   b;
        n = 0;
        b = 0;
        for (int f = 0; f < N_FRAMES; f++) begin
            for (int r = 0; r < FRAME_HEIGHT; r++) begin
                for (int c = 0; c < FRAME_WIDTH; c++) begin
                    addr = frame_base[f] + ADDR_BITS'(r * ORIG_FRAME_WIDTH + c);
                    exp_pix[n] = {(r == 0 && c == 0), addr[15:0] ^ 16'h5a5a};
                    if (c % BURST_PIX == 0) begin
                        exp_burst[b] = addr;
                        b++;
                    end
                    n++;
                end
            end
        end
    endtask

    task automatic run_frame(input int idx, input string name, input bit stall);
        int run_left;
        bit rd_on;
        run_left  = 0;
        rd_on     = 1'b0;
        test_name = name;
        frame_idx = idx;
        frame_end = (idx + 1) * FRAME_PIX;
        start     = 1'b1;
        base_addr = frame_base[idx];
        @(negedge clk);
        start = 1'b0;
        while (done_cnt != idx + 1 || queue_valid) begin
            if (stall) begin
                if (run_left == 0) begin
                    rd_on    = !rd_on;
                    run_left = rd_on ? $urandom_range(8, 1) : $urandom_range(15, 1);
                end
                run_left--;
                queue_rd = rd_on;
            end else begin
                queue_rd = 1'b1;
            end
            @(negedge clk);
        end
        // queue is empty and done has pulsed, so every entry is in by now
        assert (cons_idx == frame_end) else begin
            mismatch_cnt++;
            $display("Mismatch %s entry count: expected %0d, actual %0d", name,
                     FRAME_PIX, cons_idx - idx * FRAME_PIX);
        end
        queue_rd = 1'b1;
        repeat (2 * BURST_PIX) @(negedge clk);     // stray entries would show here
        assert (burst_idx == (idx + 1) * FRAME_BURSTS) else begin
            mismatch_cnt++;
            $display("Mismatch %s burst count: expected %0d, actual %0d", name,
                     FRAME_BURSTS, burst_idx - idx * FRAME_BURSTS);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        reset_n       = 1'b0;
        start         = 1'b0;
        base_addr     = '0;
        queue_rd      = 1'b0;
        frame_base[0] = 21'h000100;
        frame_base[1] = 21'h01fff0;                  // crosses the 16-bit pixel wrap
        frame_base[2] = 21'h000a40;
        build_reference();
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        run_frame(0, "plain_frame", 1'b0);
        run_frame(1, "backpressure", 1'b1);
        run_frame(2, "restart", 1'b0);
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: frames did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: build.f
frame_dl_pkg.sv
frame_addr_gen.sv
burst_reader.sv
download_cache.sv
frame_downloader.sv
pixel_queue.sv
frame_fetch_top.sv
tb_mem_model.sv
tb_frame_fetch.sv
